/* src/ex_pkg.sv */
/*
 * shared types and constants for the integer execute stage.
 * modules refer to these by scoped name; nothing here holds state.
 */

package ex_pkg;

	localparam int XLEN = 32; // RV32 immediate formats fix this

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0] inst_t;

	// fill words seen only on an undefined select or opcode
	localparam word_t FILL_A = 32'hdeadfbac;
	localparam word_t FILL_B = 32'hfacefeed;

	////////////////////
	// unit and function codes

	typedef enum logic [1:0] {
		UNIT_ALU = 2'd0,
		UNIT_MULT = 2'd1,
		UNIT_BRANCH = 2'd2
	} unit_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h1,
		ALU_AND = 4'h2,
		ALU_OR = 4'h3,
		ALU_XOR = 4'h4,
		ALU_SLT = 4'h5,
		ALU_SLTU = 4'h6,
		ALU_SLL = 4'h7,
		ALU_SRL = 4'h8,
		ALU_SRA = 4'h9,
		ALU_MUL = 4'ha // low half of product
	} alu_func_t;

	typedef enum logic [1:0] {
		MUL = 2'd0,
		MULH = 2'd1,
		MULHSU = 2'd2,
		MULHU = 2'd3
	} mult_func_t;

	////////////////////
	// operand selects

	typedef enum logic [1:0] {
		OPA_IS_RS1 = 2'd0,
		OPA_IS_NPC = 2'd1,
		OPA_IS_PC = 2'd2,
		OPA_IS_ZERO = 2'd3
	} opa_sel_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2 = 3'd0,
		OPB_IS_I_IMM = 3'd1,
		OPB_IS_S_IMM = 3'd2,
		OPB_IS_B_IMM = 3'd3,
		OPB_IS_U_IMM = 3'd4,
		OPB_IS_J_IMM = 3'd5
	} opb_sel_t;

	// branch compare, straight from funct3
	typedef enum logic [2:0] {
		BEQ = 3'b000,
		BNE = 3'b001,
		BLT = 3'b100,
		BGE = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} br_funct_t;

endpackage

/* src/operand_select.sv */
/*
 * issue register of the execute stage. decodes the target unit into one
 * start strobe and builds operands A and B for the cycle after issue.
 */

`timescale 1ns/1ps

module operand_select #(
	parameter int TAG_BITS = 6
) (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input ex_pkg::unit_t unit,
	input ex_pkg::alu_func_t alu_func,
	input ex_pkg::mult_func_t mult_func,
	input ex_pkg::opa_sel_t opa_select,
	input ex_pkg::opb_sel_t opb_select,
	input ex_pkg::word_t rs1_value,
	input ex_pkg::word_t rs2_value,
	input ex_pkg::word_t pc,
	input ex_pkg::word_t npc,
	input ex_pkg::inst_t inst,
	input logic [TAG_BITS-1:0] dest_tag,
	input logic cond_branch,
	input logic uncond_branch,
	output logic alu_start,
	output logic branch_start,
	output logic mult_start,
	output ex_pkg::word_t opa,
	output ex_pkg::word_t opb,
	output ex_pkg::word_t rs1,
	output ex_pkg::word_t rs2,
	output ex_pkg::word_t link,
	output logic [TAG_BITS-1:0] tag,
	output ex_pkg::alu_func_t alu_op,
	output ex_pkg::mult_func_t mult_op,
	output ex_pkg::br_funct_t br_funct,
	output logic cond,
	output logic uncond
);

	ex_pkg::word_t opa_next, opb_next;

	always_comb begin
		case (opa_select)
			ex_pkg::OPA_IS_RS1: opa_next = rs1_value;
			ex_pkg::OPA_IS_NPC: opa_next = npc;
			ex_pkg::OPA_IS_PC: opa_next = pc;
			default: opa_next = '0; // zero select
		endcase
	end

	// sign-extended immediates, RV32 bit layout
	always_comb begin
		case (opb_select)
			ex_pkg::OPB_IS_RS2: opb_next = rs2_value;
			ex_pkg::OPB_IS_I_IMM: opb_next = {{21{inst[31]}}, inst[30:20]};
			ex_pkg::OPB_IS_S_IMM: opb_next = {{21{inst[31]}}, inst[30:25], inst[11:7]};
			ex_pkg::OPB_IS_B_IMM: opb_next = {{20{inst[31]}}, inst[7], inst[30:25],
				inst[11:8], 1'b0};
			ex_pkg::OPB_IS_U_IMM: opb_next = {inst[31:12], 12'b0};
			ex_pkg::OPB_IS_J_IMM: opb_next = {{12{inst[31]}}, inst[19:12], inst[20],
				inst[30:21], 1'b0};
			default: opb_next = ex_pkg::FILL_B;
		endcase
	end

	////////////////////
	// one strobe per issued instruction
	always_ff @(posedge clock) begin
		if (reset) begin
			alu_start <= 1'b0;
			branch_start <= 1'b0;
			mult_start <= 1'b0;
		end else begin
			alu_start <= issue_valid && (unit == ex_pkg::UNIT_ALU);
			branch_start <= issue_valid && (unit == ex_pkg::UNIT_BRANCH);
			mult_start <= issue_valid && (unit == ex_pkg::UNIT_MULT);
		end
	end

	always_ff @(posedge clock) begin
		opa <= opa_next;
		opb <= opb_next;
		rs1 <= rs1_value; // raw values for compare and multiply
		rs2 <= rs2_value;
		link <= npc;
		tag <= dest_tag;
		alu_op <= alu_func;
		mult_op <= mult_func;
		br_funct <= ex_pkg::br_funct_t'(inst[14:12]);
		cond <= cond_branch;
		uncond <= uncond_branch;
	end

endmodule

/* src/int_alu.sv */
/*
 * integer ALU, purely combinational on the registered operands.
 * the result is written to the completion queue in the same cycle.
 */

`timescale 1ns/1ps

module int_alu (
	input ex_pkg::word_t opa,
	input ex_pkg::word_t opb,
	input ex_pkg::alu_func_t alu_op,
	output ex_pkg::word_t result
);

	logic signed [ex_pkg::XLEN-1:0] signed_opa, signed_opb;
	logic [4:0] shamt;
	ex_pkg::word_t product_lo;

	assign signed_opa = opa;
	assign signed_opb = opb;
	assign shamt = opb[4:0];
	assign product_lo = opa * opb; // low half is sign agnostic

	always_comb begin
		case (alu_op)
			ex_pkg::ALU_ADD: result = opa + opb;
			ex_pkg::ALU_SUB: result = opa - opb;
			ex_pkg::ALU_AND: result = opa & opb;
			ex_pkg::ALU_OR: result = opa | opb;
			ex_pkg::ALU_XOR: result = opa ^ opb;
			ex_pkg::ALU_SLT: result = {31'b0, signed_opa < signed_opb};
			ex_pkg::ALU_SLTU: result = {31'b0, opa < opb};
			ex_pkg::ALU_SLL: result = opa << shamt;
			ex_pkg::ALU_SRL: result = opa >> shamt;
			ex_pkg::ALU_SRA: result = signed_opa >>> shamt;
			ex_pkg::ALU_MUL: result = product_lo;
			default: result = ex_pkg::FILL_A;
		endcase
	end

endmodule

/* src/branch_unit.sv */
/*
 * branch resolution. compares rs1 against rs2 by funct3, decides taken,
 * and forms the target opa + opb and the link value for jumps.
 */

`timescale 1ns/1ps

module branch_unit (
	input ex_pkg::word_t rs1,
	input ex_pkg::word_t rs2,
	input ex_pkg::word_t opa,
	input ex_pkg::word_t opb,
	input ex_pkg::word_t link,
	input ex_pkg::br_funct_t br_funct,
	input logic cond,
	input logic uncond,
	output logic take,
	output ex_pkg::word_t target,
	output ex_pkg::word_t result
);

	logic signed [ex_pkg::XLEN-1:0] signed_rs1, signed_rs2;
	logic cmp;

	assign signed_rs1 = rs1;
	assign signed_rs2 = rs2;

	always_comb begin
		case (br_funct)
			ex_pkg::BEQ: cmp = rs1 == rs2;
			ex_pkg::BNE: cmp = rs1 != rs2;
			ex_pkg::BLT: cmp = signed_rs1 < signed_rs2;
			ex_pkg::BGE: cmp = signed_rs1 >= signed_rs2;
			ex_pkg::BLTU: cmp = rs1 < rs2;
			ex_pkg::BGEU: cmp = rs1 >= rs2;
			default: cmp = 1'b0; // funct3 010/011 never branch
		endcase
	end

	assign take = uncond | (cond & cmp);
	assign target = opa + opb;
	assign result = uncond ? link : '0; // jumps write the return address

endmodule

/* src/mult_pipe.sv */
/*
 * pipelined 32x32 multiplier. each stage adds one 64/MULT_STAGES-bit
 * partial product; tag and function ride along so items overlap.
 */

`timescale 1ns/1ps

module mult_pipe #(
	parameter int MULT_STAGES = 4,
	parameter int TAG_BITS = 6
) (
	input logic clock,
	input logic reset,
	input logic start,
	input ex_pkg::word_t mcand,
	input ex_pkg::word_t mplier,
	input ex_pkg::mult_func_t func,
	input logic [TAG_BITS-1:0] tag_in,
	output logic done,
	output logic [TAG_BITS-1:0] tag_out,
	output ex_pkg::word_t product
);

	localparam int SLICE = 64 / MULT_STAGES; // multiplier bits per stage

	if (64 % MULT_STAGES != 0) begin : g_stage_check
		$error("MULT_STAGES must divide 64");
	end

	logic [1:0] sign; // {mplier, mcand} signed

	// index i is the input side of stage i
	logic [63:0] mcand_s [MULT_STAGES];
	logic [63:0] mplier_s [MULT_STAGES];
	logic [63:0] prod_s [MULT_STAGES+1];
	logic valid_s [MULT_STAGES+1];
	logic [TAG_BITS-1:0] tag_s [MULT_STAGES+1];
	ex_pkg::mult_func_t func_s [MULT_STAGES+1];

	always_comb begin
		case (func)
			ex_pkg::MULHSU: sign = 2'b01;
			ex_pkg::MULHU: sign = 2'b00;
			default: sign = 2'b11; // MUL, MULH
		endcase
	end

	assign mcand_s[0] = sign[0] ? {{32{mcand[31]}}, mcand} : {32'b0, mcand};
	assign mplier_s[0] = sign[1] ? {{32{mplier[31]}}, mplier} : {32'b0, mplier};
	assign prod_s[0] = '0;
	assign valid_s[0] = start;
	assign tag_s[0] = tag_in;
	assign func_s[0] = func;

	////////////////////
	// partial-product stages
	for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
		always_ff @(posedge clock) begin
			if (reset)
				valid_s[i+1] <= 1'b0;
			else
				valid_s[i+1] <= valid_s[i];
		end

		always_ff @(posedge clock) begin
			prod_s[i+1] <= prod_s[i] + mplier_s[i][SLICE-1:0] * mcand_s[i];
			tag_s[i+1] <= tag_s[i];
			func_s[i+1] <= func_s[i];
		end

		// last stage has no one to hand operands to
		if (i < MULT_STAGES - 1) begin : g_shift
			always_ff @(posedge clock) begin
				mplier_s[i+1] <= mplier_s[i] >> SLICE;
				mcand_s[i+1] <= mcand_s[i] << SLICE;
			end
		end
	end

	assign done = valid_s[MULT_STAGES];
	assign tag_out = tag_s[MULT_STAGES];

	always_comb begin
		case (func_s[MULT_STAGES])
			ex_pkg::MUL: product = prod_s[MULT_STAGES][31:0];
			default: product = prod_s[MULT_STAGES][63:32]; // high half
		endcase
	end

endmodule

/* src/completion_queue.sv */
/*
 * circular completion queue. takes up to two entries a cycle, multiplier
 * first, and presents the head combinationally, popping it every cycle.
 */

`timescale 1ns/1ps

module completion_queue #(
	parameter int QUEUE_DEPTH = 8,
	parameter int TAG_BITS = 6,
	parameter int MULT_STAGES = 4
) (
	input logic clock,
	input logic reset,
	input logic mult_done,
	input logic [TAG_BITS-1:0] mult_tag,
	input ex_pkg::word_t mult_result,
	input logic alu_start,
	input logic branch_start,
	input logic [TAG_BITS-1:0] int_tag,
	input ex_pkg::word_t alu_result,
	input ex_pkg::word_t branch_result,
	input logic branch_take,
	input ex_pkg::word_t branch_target,
	output logic complete_valid,
	output logic [TAG_BITS-1:0] complete_tag,
	output ex_pkg::word_t complete_result,
	output logic complete_take,
	output ex_pkg::word_t complete_target,
	output logic reg_wr_en
);

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	if (QUEUE_DEPTH < MULT_STAGES + 2) begin : g_depth_check
		$error("QUEUE_DEPTH must be at least MULT_STAGES + 2");
	end

	logic [TAG_BITS-1:0] tag_q [QUEUE_DEPTH];
	ex_pkg::word_t result_q [QUEUE_DEPTH];
	logic take_q [QUEUE_DEPTH];
	ex_pkg::word_t target_q [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] head, tail;
	logic [PTR_BITS-1:0] int_ptr; // slot for the ALU/branch entry
	logic [CNT_BITS-1:0] count;
	logic [1:0] num_writes;
	logic int_valid, pop;

	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
		ptr_inc = (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign int_valid = alu_start | branch_start;
	assign int_ptr = mult_done ? ptr_inc(tail) : tail;
	assign num_writes = {1'b0, mult_done} + {1'b0, int_valid};
	assign pop = count != '0;

	////////////////////
	// entry storage
	always_ff @(posedge clock) begin
		if (mult_done) begin
			tag_q[tail] <= mult_tag;
			result_q[tail] <= mult_result;
			take_q[tail] <= 1'b0;
			target_q[tail] <= '0;
		end
		if (int_valid) begin
			tag_q[int_ptr] <= int_tag;
			result_q[int_ptr] <= branch_start ? branch_result : alu_result;
			take_q[int_ptr] <= branch_start & branch_take;
			target_q[int_ptr] <= branch_start ? branch_target : '0; // zero for ALU
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			tail <= int_valid ? ptr_inc(int_ptr) : int_ptr;
			if (pop)
				head <= ptr_inc(head);
			count <= count + CNT_BITS'(num_writes) - CNT_BITS'(pop);
		end
	end

	assign complete_valid = pop;
	assign complete_tag = tag_q[head];
	assign complete_result = result_q[head];
	assign complete_take = take_q[head];
	assign complete_target = target_q[head];
	assign reg_wr_en = complete_valid && (complete_tag != '0); // tag 0 is x0

endmodule

/* src/ex_stage.sv */
/*
 * integer execute stage, top level. issue register feeds the ALU, branch
 * unit and multiplier; all results leave through the completion queue.
 */

`timescale 1ns/1ps

module ex_stage #(
	parameter int TAG_BITS = 6,
	parameter int MULT_STAGES = 4,
	parameter int QUEUE_DEPTH = 8
) (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input ex_pkg::unit_t unit,
	input ex_pkg::alu_func_t alu_func,
	input ex_pkg::mult_func_t mult_func,
	input ex_pkg::opa_sel_t opa_select,
	input ex_pkg::opb_sel_t opb_select,
	input ex_pkg::word_t rs1_value,
	input ex_pkg::word_t rs2_value,
	input ex_pkg::word_t pc,
	input ex_pkg::word_t npc,
	input ex_pkg::inst_t inst,
	input logic [TAG_BITS-1:0] dest_tag,
	input logic cond_branch,
	input logic uncond_branch,
	output logic complete_valid,
	output logic [TAG_BITS-1:0] complete_tag,
	output ex_pkg::word_t complete_result,
	output logic complete_take,
	output ex_pkg::word_t complete_target,
	output logic reg_wr_en
);

	logic alu_start, branch_start, mult_start;
	ex_pkg::word_t opa, opb, rs1, rs2, link;
	logic [TAG_BITS-1:0] int_tag;
	ex_pkg::alu_func_t alu_op;
	ex_pkg::mult_func_t mult_op;
	ex_pkg::br_funct_t br_funct;
	logic cond, uncond;

	ex_pkg::word_t alu_result, branch_result, branch_target, mult_result;
	logic branch_take;
	logic mult_done;
	logic [TAG_BITS-1:0] mult_tag;

	////////////////////
	// issue register
	operand_select #(.TAG_BITS(TAG_BITS)) u_operand_select (
		.clock(clock), .reset(reset), .issue_valid(issue_valid), .unit(unit),
		.alu_func(alu_func), .mult_func(mult_func),
		.opa_select(opa_select), .opb_select(opb_select),
		.rs1_value(rs1_value), .rs2_value(rs2_value), .pc(pc), .npc(npc),
		.inst(inst), .dest_tag(dest_tag),
		.cond_branch(cond_branch), .uncond_branch(uncond_branch),
		.alu_start(alu_start), .branch_start(branch_start), .mult_start(mult_start),
		.opa(opa), .opb(opb), .rs1(rs1), .rs2(rs2), .link(link), .tag(int_tag),
		.alu_op(alu_op), .mult_op(mult_op), .br_funct(br_funct),
		.cond(cond), .uncond(uncond)
	);

	////////////////////
	// functional units
	int_alu u_int_alu (.opa(opa), .opb(opb), .alu_op(alu_op), .result(alu_result));

	branch_unit u_branch_unit (
		.rs1(rs1), .rs2(rs2), .opa(opa), .opb(opb), .link(link),
		.br_funct(br_funct), .cond(cond), .uncond(uncond),
		.take(branch_take), .target(branch_target), .result(branch_result)
	);

	mult_pipe #(.MULT_STAGES(MULT_STAGES), .TAG_BITS(TAG_BITS)) u_mult_pipe (
		.clock(clock), .reset(reset), .start(mult_start),
		.mcand(rs1), .mplier(rs2), .func(mult_op), .tag_in(int_tag),
		.done(mult_done), .tag_out(mult_tag), .product(mult_result)
	);

	////////////////////
	// completion
	completion_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH), .TAG_BITS(TAG_BITS), .MULT_STAGES(MULT_STAGES)
	) u_completion_queue (
		.clock(clock), .reset(reset),
		.mult_done(mult_done), .mult_tag(mult_tag), .mult_result(mult_result),
		.alu_start(alu_start), .branch_start(branch_start), .int_tag(int_tag),
		.alu_result(alu_result), .branch_result(branch_result),
		.branch_take(branch_take), .branch_target(branch_target),
		.complete_valid(complete_valid), .complete_tag(complete_tag),
		.complete_result(complete_result), .complete_take(complete_take),
		.complete_target(complete_target), .reg_wr_en(reg_wr_en)
	);

endmodule

/* bench/ex_stage_checker.sv */
/*
 * assertions bound into the completion queue. watch for writes into a
 * full queue, quiet output around reset and a lone write enable.
 */

`timescale 1ns/1ps

module ex_stage_checker #(
	parameter int QUEUE_DEPTH = 8
) (
	input logic clock,
	input logic reset,
	input logic mult_done,
	input logic alu_start,
	input logic branch_start,
	input logic complete_valid,
	input logic reg_wr_en,
	input logic [$clog2(QUEUE_DEPTH+1)-1:0] count
);

	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	logic any_write;

	assign any_write = mult_done | alu_start | branch_start;

	no_write_when_full: assert property (@(posedge clock) disable iff (reset)
		(count == CNT_BITS'(QUEUE_DEPTH)) |-> !any_write)
		else $error("write into a full completion queue");

	quiet_after_reset: assert property (@(posedge clock) reset |=> !complete_valid)
		else $error("complete_valid high during or right after reset");

	wr_en_needs_valid: assert property (@(posedge clock) disable iff (reset)
		reg_wr_en |-> complete_valid)
		else $error("reg_wr_en high without complete_valid");

endmodule

/* bench/ex_stage_tb.sv */
/*
 * testbench for the integer execute stage. drives random and directed issues
 * from an LFSR, predicts each completion with a reference model and checks
 * every completion by tag, in whatever order it leaves the queue.
 */

`timescale 1ns/1ps

module ex_stage_tb;

	localparam int TAG_BITS = 6;
	localparam int MULT_STAGES = 4;
	localparam int QUEUE_DEPTH = 8;
	localparam int NUM_INSTS = 400;
	localparam int NUM_TAGS = 1 << TAG_BITS;
	localparam int CYCLE_LIMIT = 16 + NUM_INSTS * 2 + MULT_STAGES + QUEUE_DEPTH + 50;

	logic clock = 1'b0;
	logic reset;
	logic issue_valid;
	ex_pkg::unit_t unit;
	ex_pkg::alu_func_t alu_func;
	ex_pkg::mult_func_t mult_func;
	ex_pkg::opa_sel_t opa_select;
	ex_pkg::opb_sel_t opb_select;
	ex_pkg::word_t rs1_value, rs2_value, pc, npc;
	ex_pkg::inst_t inst;
	logic [TAG_BITS-1:0] dest_tag;
	logic cond_branch, uncond_branch;

	logic complete_valid, complete_take, reg_wr_en;
	logic [TAG_BITS-1:0] complete_tag;
	ex_pkg::word_t complete_result, complete_target;

	// scoreboard, one slot per tag
	ex_pkg::word_t exp_result [NUM_TAGS];
	logic exp_take [NUM_TAGS];
	ex_pkg::word_t exp_target [NUM_TAGS];
	logic exp_wr_en [NUM_TAGS];
	int issued_cnt [NUM_TAGS];
	int done_cnt [NUM_TAGS];

	int value_errors = 0;
	int protocol_errors = 0;
	int checked = 0;
	int cycle_count = 0;
	logic [31:0] lfsr_state = 32'h221a2bb0;

	ex_stage #(
		.TAG_BITS(TAG_BITS), .MULT_STAGES(MULT_STAGES), .QUEUE_DEPTH(QUEUE_DEPTH)
	) UUT (.*);

	bind completion_queue ex_stage_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_checker (
		.clock(clock), .reset(reset), .mult_done(mult_done), .alu_start(alu_start),
		.branch_start(branch_start), .complete_valid(complete_valid),
		.reg_wr_en(reg_wr_en), .count(count)
	);

	always #10 clock = ~clock;

	////////////////////
	// random source

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic draw_bits(input int width, output logic [31:0] value);
		value = '0;
		for (int k = 0; k < width; k++) begin
			value = {value[30:0], lfsr_state[0]}; // one step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	////////////////////
	// reference model

	function automatic void reference_model(
		input ex_pkg::unit_t u, input ex_pkg::alu_func_t af, input ex_pkg::mult_func_t mf,
		input ex_pkg::opa_sel_t sa, input ex_pkg::opb_sel_t sb,
		input ex_pkg::word_t r1, input ex_pkg::word_t r2,
		input ex_pkg::word_t p, input ex_pkg::word_t np, input ex_pkg::inst_t ins,
		input logic c, input logic j,
		output ex_pkg::word_t result, output logic take, output ex_pkg::word_t target);
		ex_pkg::word_t a, b;
		logic [63:0] xa, xb, full;
		logic cmp;
		case (sa)
			ex_pkg::OPA_IS_RS1: a = r1;
			ex_pkg::OPA_IS_NPC: a = np;
			ex_pkg::OPA_IS_PC: a = p;
			default: a = 32'h0;
		endcase
		case (sb)
			ex_pkg::OPB_IS_RS2: b = r2;
			ex_pkg::OPB_IS_I_IMM: b = {{20{ins[31]}}, ins[31:20]};
			ex_pkg::OPB_IS_S_IMM: b = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			ex_pkg::OPB_IS_B_IMM: b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			ex_pkg::OPB_IS_U_IMM: b = {ins[31:12], 12'h000};
			ex_pkg::OPB_IS_J_IMM: b = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			default: b = ex_pkg::FILL_B;
		endcase
		result = '0;
		take = 1'b0;
		target = '0;
		case (u)
			ex_pkg::UNIT_ALU: begin
				case (af)
					ex_pkg::ALU_ADD: result = a + b;
					ex_pkg::ALU_SUB: result = a - b;
					ex_pkg::ALU_AND: result = a & b;
					ex_pkg::ALU_OR: result = a | b;
					ex_pkg::ALU_XOR: result = a ^ b;
					ex_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
					ex_pkg::ALU_SLTU: result = {31'b0, a < b};
					ex_pkg::ALU_SLL: result = a << b[4:0];
					ex_pkg::ALU_SRL: result = a >> b[4:0];
					ex_pkg::ALU_SRA: result = $signed(a) >>> b[4:0];
					ex_pkg::ALU_MUL: result = a * b;
					default: result = ex_pkg::FILL_A;
				endcase
			end
			ex_pkg::UNIT_MULT: begin
				// rs1 signed unless MULHU, rs2 signed only for MUL and MULH
				xa = (mf == ex_pkg::MULHU) ? {32'b0, r1} : {{32{r1[31]}}, r1};
				xb = (mf == ex_pkg::MUL || mf == ex_pkg::MULH) ? {{32{r2[31]}}, r2} : {32'b0, r2};
				full = xa * xb;
				result = (mf == ex_pkg::MUL) ? full[31:0] : full[63:32];
			end
			default: begin
				case (ins[14:12])
					3'b000: cmp = r1 == r2;
					3'b001: cmp = r1 != r2;
					3'b100: cmp = $signed(r1) < $signed(r2);
					3'b101: cmp = $signed(r1) >= $signed(r2);
					3'b110: cmp = r1 < r2;
					3'b111: cmp = r1 >= r2;
					default: cmp = 1'b0;
				endcase
				take = j || (c && cmp);
				target = a + b;
				result = j ? np : 32'h0; // link value only for jumps
			end
		endcase
	endfunction

	////////////////////
	// stimulus

	task automatic drive_issue(
		input ex_pkg::unit_t u, input ex_pkg::alu_func_t af, input ex_pkg::mult_func_t mf,
		input ex_pkg::opa_sel_t sa, input ex_pkg::opb_sel_t sb,
		input ex_pkg::word_t r1, input ex_pkg::word_t r2, input ex_pkg::word_t p,
		input ex_pkg::inst_t ins, input logic [TAG_BITS-1:0] t, input logic c, input logic j);
		ex_pkg::word_t res, tgt;
		logic tk;
		reference_model(u, af, mf, sa, sb, r1, r2, p, p + 32'd4, ins, c, j, res, tk, tgt);
		exp_result[t] = res;
		exp_take[t] = tk;
		exp_target[t] = tgt;
		exp_wr_en[t] = (t != 0); // x0 is never written
		issued_cnt[t]++;
		issue_valid <= 1'b1;
		unit <= u;
		alu_func <= af;
		mult_func <= mf;
		opa_select <= sa;
		opb_select <= sb;
		rs1_value <= r1;
		rs2_value <= r2;
		pc <= p;
		npc <= p + 32'd4;
		inst <= ins;
		dest_tag <= t;
		cond_branch <= c;
		uncond_branch <= j;
	endtask

	task automatic issue_random(input int n);
		logic [31:0] r1, r2, p, ins, bits;
		logic [3:0] af_bits;
		logic [2:0] f3, sb_bits;
		logic [1:0] mf_bits, sa_bits;
		ex_pkg::unit_t u;
		logic c, j;
		if (n < 80)
			u = ex_pkg::UNIT_ALU;
		else if (n < 160)
			u = ex_pkg::UNIT_MULT;
		else if (n < 240)
			u = ex_pkg::UNIT_BRANCH;
		else begin
			draw_bits(2, bits);
			u = ex_pkg::unit_t'(2'(bits % 3)); // mixed stream
		end
		draw_bits(32, r1);
		draw_bits(32, r2);
		draw_bits(2, bits);
		if (bits == 0)
			r2 = r1; // equal operands for the compares
		draw_bits(32, p);
		draw_bits(32, ins);
		c = 1'b0;
		j = 1'b0;
		if (u == ex_pkg::UNIT_BRANCH) begin
			draw_bits(2, bits);
			j = (bits == 0);
			c = !j;
			draw_bits(3, bits);
			case (bits % 6)
				0: f3 = 3'b000;
				1: f3 = 3'b001;
				2: f3 = 3'b100;
				3: f3 = 3'b101;
				4: f3 = 3'b110;
				default: f3 = 3'b111;
			endcase
			ins[14:12] = f3;
		end
		draw_bits(4, bits);
		af_bits = 4'(bits % 11);
		draw_bits(2, bits);
		mf_bits = bits[1:0];
		draw_bits(2, bits);
		sa_bits = bits[1:0];
		draw_bits(3, bits);
		sb_bits = bits[2:0]; // 6 and 7 are undefined selects
		drive_issue(u, ex_pkg::alu_func_t'(af_bits), ex_pkg::mult_func_t'(mf_bits),
			ex_pkg::opa_sel_t'(sa_bits), ex_pkg::opb_sel_t'(sb_bits),
			r1, r2, p, ins, TAG_BITS'((n % 63) + 1), c, j);
	endtask

	function automatic int outstanding();
		int total;
		total = 0;
		for (int t = 0; t < NUM_TAGS; t++)
			if (issued_cnt[t] != done_cnt[t])
				total++;
		return total;
	endfunction

	////////////////////
	// checks

	task automatic check_result(input logic [TAG_BITS-1:0] t, input ex_pkg::word_t got,
		input ex_pkg::word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %0t: tag %0d result %h, expected %h", $time, t, got, exp);
		end
	endtask

	task automatic check_branch(input logic [TAG_BITS-1:0] t, input logic got_take,
		input ex_pkg::word_t got_target, input logic exp_tk, input ex_pkg::word_t exp_tgt);
		if (got_take !== exp_tk || got_target !== exp_tgt) begin
			value_errors++;
			$display("FAIL %0t: tag %0d take %b target %h, expected take %b target %h",
				$time, t, got_take, got_target, exp_tk, exp_tgt);
		end
	endtask

	task automatic check_write_enable(input logic [TAG_BITS-1:0] t, input logic got,
		input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %0t: tag %0d reg_wr_en %b, expected %b", $time, t, got, exp);
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clock) begin
		if (!reset && complete_valid === 1'b1) begin
			if (done_cnt[complete_tag] >= issued_cnt[complete_tag]) begin
				protocol_errors++;
				$display("completion at %0t for tag %0d which was never issued or already done",
					$time, complete_tag);
			end else begin
				check_result(complete_tag, complete_result, exp_result[complete_tag]);
				check_branch(complete_tag, complete_take, complete_target,
					exp_take[complete_tag], exp_target[complete_tag]);
				check_write_enable(complete_tag, reg_wr_en, exp_wr_en[complete_tag]);
				done_cnt[complete_tag]++;
				checked++;
			end
		end else if (!reset && complete_valid !== 1'b0) begin
			protocol_errors++;
			$display("complete_valid is unknown at %0t", $time);
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles with %0d tags still waiting for completion",
				cycle_count, outstanding());
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		int n;
		logic [31:0] bits;
		reset = 1'b1;
		issue_valid = 1'b0;
		unit = ex_pkg::UNIT_ALU;
		alu_func = ex_pkg::ALU_ADD;
		mult_func = ex_pkg::MUL;
		opa_select = ex_pkg::OPA_IS_RS1;
		opb_select = ex_pkg::OPB_IS_RS2;
		rs1_value = '0;
		rs2_value = '0;
		pc = '0;
		npc = '0;
		inst = '0;
		dest_tag = '0;
		cond_branch = 1'b0;
		uncond_branch = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		n = 0;
		while (n < NUM_INSTS) begin
			draw_bits(2, bits);
			if (bits == 0 && !(n >= 80 && n < 160))
				issue_valid <= 1'b0; // idle gap, multiplies stay back to back
			else begin
				issue_random(n);
				n++;
			end
			@(posedge clock);
		end
		// add into x0, must not write the register file
		drive_issue(ex_pkg::UNIT_ALU, ex_pkg::ALU_ADD, ex_pkg::MUL, ex_pkg::OPA_IS_RS1,
			ex_pkg::OPB_IS_I_IMM, 32'h0000_1000, 32'h0, 32'h0000_0400, 32'h7ff0_0013,
			'0, 1'b0, 1'b0);
		@(posedge clock);
		issue_valid <= 1'b0;
		while (outstanding() != 0)
			@(posedge clock);
		repeat (QUEUE_DEPTH) @(posedge clock); // catch late strays
		$display("completions checked %0d, value errors %0d, protocol errors %0d",
			checked, value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* ex_stage.f */
src/ex_pkg.sv
src/operand_select.sv
src/int_alu.sv
src/branch_unit.sv
src/mult_pipe.sv
src/completion_queue.sv
src/ex_stage.sv
bench/ex_stage_checker.sv
bench/ex_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute stage testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module ex_stage_tb -f ex_stage.f -Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/ex_stage_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF '>>> PASS'; then
	exit 0
fi
exit 1
